// File: tb.f
+incdir+hw
hw/tl2umi_pkg.sv
hw/tl_a_decode.sv
hw/umi_req_issue.sv
hw/umi_resp_convert.sv
hw/tl2umi_bridge.sv
sim/tl2umi_checker.sv
sim/tb_tl2umi.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the bridge testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_tl2umi \
    -f tb.f -o tb_tl2umi \
    && ./obj_dir/tb_tl2umi > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// File: sim/tb_tl2umi.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module tb_tl2umi
    import tl2umi_pkg::*;
();

    localparam int NUM_TESTS      = 200;
    localparam int TIMEOUT_CYCLES = 5 + NUM_TESTS * 40;

    logic                   clk;
    logic                   nreset;
    logic [`TL2UMI_IDW-1:0] chipid;
    logic                   tl_a_valid;
    logic                   tl_a_ready;
    tl_a_beat_t             tl_a;
    logic                   tl_d_valid;
    logic                   tl_d_ready;
    tl_d_beat_t             tl_d;
    logic [1:0]             tl_d_param;
    logic                   tl_d_sink;
    logic                   tl_d_denied;
    logic                   tl_d_corrupt;
    logic                   uhost_req_valid;
    logic                   uhost_req_ready;
    umi_packet_t            uhost_req;
    logic                   uhost_resp_valid;
    logic                   uhost_resp_ready;
    umi_packet_t            uhost_resp;
    int                     errors;
    int                     tests;
    int                     outstanding;
    integer                 seed = 32'h546a;
    logic [7:0]             mem [256];

    tl2umi_bridge dut (.*);

    tl2umi_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Gets of size 0..3, full or partial Puts, and now and then an unsupported opcode
    task automatic make_beat(output tl_a_beat_t b);
        int pick;
        int lo;
        int n;
        b         = '0;
        pick      = $random(seed) & 15;
        b.source  = 5'($random(seed));
        b.data    = {$random(seed), $random(seed)};
        b.address = {48'h123456789ABC, 8'($random(seed))};
        if (pick < 7) begin
            b.opcode         = TL_A_GET;
            b.size           = 3'($random(seed) & 3);
            lo               = int'(b.address[2:0]) & ~((1 << b.size) - 1);
            b.address[2:0]   = 3'(lo);
            b.mask           = 8'(((1 << (1 << b.size)) - 1) << lo);
        end else begin
            b.size         = 3'd3;
            b.address[2:0] = 3'd0;
            b.mask         = 8'hFF;
            if (pick < 10) begin
                b.opcode = TL_A_PUT_FULL;
            end else if (pick < 15) begin
                b.opcode = TL_A_PUT_PARTIAL;
                lo       = $random(seed) & 7;
                n        = 1 + (($random(seed) & 32'h7fff_ffff) % (8 - lo));
                b.mask   = 8'(((1 << n) - 1) << lo);
            end else begin
                b.opcode = tl_a_op_e'(3'd2);
            end
        end
    endtask

    // UMI memory model serving one request at a time
    task automatic answer(input umi_packet_t req, output umi_packet_t resp);
        logic [7:0] base;
        resp         = '0;
        base         = req.dstaddr[7:0];
        resp.dstaddr = req.srcaddr;
        resp.cmd.len = req.cmd.len;
        resp.cmd.eom = 1'b1;
        if (req.cmd.opcode == UMI_REQ_WRITE) begin
            resp.cmd.opcode = UMI_RESP_WRITE;
            for (int i = 0; i <= int'(req.cmd.len); i++) begin
                mem[base + 8'(i)] = req.data[8*i +: 8];
            end
        end else begin
            resp.cmd.opcode = UMI_RESP_READ;
            for (int i = 0; i <= int'(req.cmd.len); i++) begin
                resp.data[8*i +: 8] = mem[base + 8'(i)];
            end
        end
    endtask

    initial begin
        tl_a_beat_t beat;
        chipid     = 16'h00A5;
        nreset     = 1'b0;
        tl_a_valid = 1'b0;
        tl_a       = '0;
        repeat (5) @(negedge clk);
        nreset = 1'b1;
        for (int n = 0; n < NUM_TESTS; n++) begin
            make_beat(beat);
            tl_a       = beat;
            tl_a_valid = 1'b1;
            @(posedge clk);
            while (!tl_a_ready) begin
                @(posedge clk);
            end
            @(negedge clk);
            tl_a_valid = 1'b0;
            if (($random(seed) & 3) == 0) begin
                @(negedge clk);
            end
        end
        while (outstanding != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        $display("Tests completed: %0d of %0d, errors: %0d", tests, NUM_TESTS, errors);
        if (errors == 0 && tests == NUM_TESTS) begin
            $display("Result: PASSED");
        end else begin
            if (tests != NUM_TESTS) begin
                $display("Some A beats never completed their test");
            end
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        tl_d_ready = 1'b0;
        forever begin
            @(negedge clk);
            tl_d_ready = ($random(seed) & 3) != 0;
        end
    end

    initial begin
        umi_packet_t req;
        umi_packet_t resp;
        int          delay;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i * 7) ^ 8'h3C;
        end
        uhost_req_ready  = 1'b0;
        uhost_resp_valid = 1'b0;
        uhost_resp       = '0;
        forever begin
            @(negedge clk);
            uhost_resp_valid = 1'b0;
            uhost_req_ready  = ($random(seed) & 3) != 0;
            @(posedge clk);
            if (uhost_req_valid && uhost_req_ready) begin
                req = uhost_req;
                @(negedge clk);
                uhost_req_ready = 1'b0;
                delay           = $random(seed) & 7;
                repeat (delay) @(negedge clk);
                answer(req, resp);
                uhost_resp       = resp;
                uhost_resp_valid = 1'b1;
                @(posedge clk);
                while (!uhost_resp_ready) begin
                    @(posedge clk);
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: sim/tl2umi_checker.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module tl2umi_checker
    import tl2umi_pkg::*;
(
    input  logic                   clk,
    input  logic                   nreset,
    input  logic [`TL2UMI_IDW-1:0] chipid,
    input  logic                   tl_a_valid,
    input  logic                   tl_a_ready,
    input  tl_a_beat_t             tl_a,
    input  logic                   tl_d_valid,
    input  logic                   tl_d_ready,
    input  tl_d_beat_t             tl_d,
    input  logic [1:0]             tl_d_param,
    input  logic                   tl_d_sink,
    input  logic                   tl_d_denied,
    input  logic                   tl_d_corrupt,
    input  logic                   uhost_req_valid,
    input  logic                   uhost_req_ready,
    input  umi_packet_t            uhost_req,
    input  logic                   uhost_resp_ready,
    output int                     errors,
    output int                     tests,
    output int                     outstanding
);

    logic [7:0]  shadow [256];
    umi_packet_t req_q[$];
    tl_d_beat_t  d_q[$];
    int          id_q[$];
    int          err_q[$];
    int          a_count;
    logic        put_pending;
    logic        d_held;
    logic        was_up;
    tl_d_beat_t  held_d;

    initial begin
        errors      = 0;
        tests       = 0;
        outstanding = 0;
        a_count     = 0;
        put_pending = 1'b0;
        d_held      = 1'b0;
        was_up      = 1'b0;
        held_d      = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 8'(i * 7) ^ 8'h3C;
        end
    end

    // Expected UMI request for one A beat
    function automatic umi_packet_t expected_req(input tl_a_beat_t a,
                                                 input logic [`TL2UMI_IDW-1:0] id);
        umi_packet_t p;
        int          lo;
        int          cnt;
        p   = '0;
        lo  = 8;
        cnt = 0;
        for (int i = 0; i < 8; i++) begin
            if (a.mask[i]) begin
                cnt++;
                if (lo == 8) begin
                    lo = i;
                end
            end
        end
        p.cmd.eom = 1'b1;
        if (a.opcode == TL_A_GET) begin
            p.cmd.opcode = UMI_REQ_READ;
            p.cmd.len    = 8'((1 << a.size) - 1);
        end else begin
            p.cmd.opcode = UMI_REQ_WRITE;
            p.cmd.len    = 8'(cnt - 1);
            p.data       = a.data >> (8 * lo);
        end
        p.dstaddr[`TL2UMI_TLAW-1:0] = {a.address[`TL2UMI_TLAW-1:3], 3'(lo)};
        p.srcaddr[`TL2UMI_CHIPID_LSB +: `TL2UMI_IDW] = id;
        p.srcaddr[`TL2UMI_SRC_OFS_LSB +: 3]  = 3'(lo);
        p.srcaddr[`TL2UMI_SRC_SIZE_LSB +: 3] = a.size;
        p.srcaddr[`TL2UMI_SRC_ID_LSB +: 5]   = a.source;
        return p;
    endfunction

    // Expected D beat for one A beat with read data from the shadow memory
    function automatic tl_d_beat_t expected_d(input tl_a_beat_t a);
        tl_d_beat_t d;
        logic [7:0] base;
        d        = '0;
        d.size   = a.size;
        d.source = a.source;
        base     = {a.address[7:3], 3'b000};
        if (a.opcode == TL_A_GET) begin
            d.opcode = TL_D_ACCESS_ACK_DATA;
            for (int i = 0; i < 8; i++) begin
                if (a.mask[i]) begin
                    d.data[8*i +: 8] = shadow[base + 8'(i)];
                end
            end
        end else begin
            d.opcode = TL_D_ACCESS_ACK;
        end
        return d;
    endfunction

    task automatic write_shadow(input tl_a_beat_t a);
        logic [7:0] base;
        base = {a.address[7:3], 3'b000};
        for (int i = 0; i < 8; i++) begin
            if (a.mask[i]) begin
                shadow[base + 8'(i)] = a.data[8*i +: 8];
            end
        end
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        umi_packet_t exp_req;
        tl_d_beat_t  exp_d;
        int          id;
        int          e0;
        // First edge out of reset
        if (nreset && !was_up) begin
            was_up = 1'b1;
            if ({tl_d_valid, uhost_req_valid, tl_a_ready, uhost_resp_ready} !== 4'b0011) begin
                $display("%0t: handshake outputs are not in their reset state", $time);
                errors++;
            end
        end
        if (d_held && (!tl_d_valid || tl_d !== held_d)) begin
            $display("%0t: D beat changed or dropped while it was held", $time);
            errors++;
        end
        if (tl_d_valid && tl_d_ready) begin
            if (d_q.size() == 0) begin
                $display("%0t: D beat with no A beat waiting for it", $time);
                errors++;
            end else begin
                exp_d = d_q.pop_front();
                id    = id_q.pop_front();
                e0    = err_q.pop_front();
                compare("tl_d.opcode", 64'(exp_d.opcode), 64'(tl_d.opcode));
                compare("tl_d.size", 64'(exp_d.size), 64'(tl_d.size));
                compare("tl_d.source", 64'(exp_d.source), 64'(tl_d.source));
                compare("tl_d.data", exp_d.data, tl_d.data);
                // Fields that are tied off in the bridge
                compare("tl_d_param", 64'd0, 64'(tl_d_param));
                compare("tl_d_sink", 64'd0, 64'(tl_d_sink));
                compare("tl_d_denied", 64'd0, 64'(tl_d_denied));
                compare("tl_d_corrupt", 64'd0, 64'(tl_d_corrupt));
                if (exp_d.opcode == TL_D_ACCESS_ACK) begin
                    put_pending = 1'b0;
                end
                tests++;
                $display("test %0d %s %s", id,
                         (exp_d.opcode == TL_D_ACCESS_ACK) ? "Put" : "Get",
                         (errors == e0) ? "ok" : "mismatch");
            end
        end
        if (uhost_req_valid && uhost_req_ready) begin
            if (req_q.size() == 0) begin
                $display("%0t: UMI request with no A beat behind it", $time);
                errors++;
            end else begin
                exp_req = req_q.pop_front();
                compare("uhost_req.cmd", 64'(exp_req.cmd), 64'(uhost_req.cmd));
                compare("uhost_req.dstaddr", exp_req.dstaddr, uhost_req.dstaddr);
                compare("uhost_req.srcaddr", exp_req.srcaddr, uhost_req.srcaddr);
                compare("uhost_req.data", exp_req.data, uhost_req.data);
            end
        end
        if (tl_a_valid && tl_a_ready) begin
            a_count++;
            if (put_pending) begin
                $display("%0t: A beat accepted before the Put got its AccessAck", $time);
                errors++;
            end
            if (tl_a.opcode == TL_A_GET || tl_a.opcode == TL_A_PUT_FULL ||
                tl_a.opcode == TL_A_PUT_PARTIAL) begin
                req_q.push_back(expected_req(tl_a, chipid));
                d_q.push_back(expected_d(tl_a));
                id_q.push_back(a_count);
                err_q.push_back(errors);
                if (tl_a.opcode != TL_A_GET) begin
                    write_shadow(tl_a);
                    put_pending = 1'b1;
                end
            end else begin
                tests++;
                $display("test %0d opcode %0d dropped", a_count, tl_a.opcode);
            end
        end
        d_held      = tl_d_valid && !tl_d_ready;
        held_d      = tl_d;
        outstanding = req_q.size() + d_q.size();
    end

endmodule

// File: hw/tl2umi_bridge.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module tl2umi_bridge
    import tl2umi_pkg::*;
(
    input  logic                   clk,
    input  logic                   nreset,
    input  logic [`TL2UMI_IDW-1:0] chipid,
    input  logic                   tl_a_valid,
    output logic                   tl_a_ready,
    input  tl_a_beat_t             tl_a,
    output logic                   tl_d_valid,
    input  logic                   tl_d_ready,
    output tl_d_beat_t             tl_d,
    output logic [1:0]             tl_d_param,
    output logic                   tl_d_sink,
    output logic                   tl_d_denied,
    output logic                   tl_d_corrupt,
    output logic                   uhost_req_valid,
    input  logic                   uhost_req_ready,
    output umi_packet_t            uhost_req,
    input  logic                   uhost_resp_valid,
    output logic                   uhost_resp_ready,
    input  umi_packet_t            uhost_resp
);

    a_decoded_t a_dec;
    logic       put_acked;

    assign tl_d_param   = 2'b00;
    assign tl_d_sink    = 1'b0;
    assign tl_d_denied  = 1'b0;
    assign tl_d_corrupt = 1'b0;

    tl_a_decode u_decode (
        .clk     (clk),
        .nreset  (nreset),
        .valid   (tl_a_valid),
        .beat    (tl_a),
        .decoded (a_dec)
    );

    umi_req_issue u_issue (
        .clk       (clk),
        .nreset    (nreset),
        .chipid    (chipid),
        .a_valid   (tl_a_valid),
        .decoded   (a_dec),
        .a_ready   (tl_a_ready),
        .put_acked (put_acked),
        .req_valid (uhost_req_valid),
        .req_ready (uhost_req_ready),
        .req       (uhost_req)
    );

    umi_resp_convert u_resp (
        .clk        (clk),
        .nreset     (nreset),
        .resp_valid (uhost_resp_valid),
        .resp       (uhost_resp),
        .resp_ready (uhost_resp_ready),
        .d_valid    (tl_d_valid),
        .d_ready    (tl_d_ready),
        .d          (tl_d),
        .put_acked  (put_acked)
    );

endmodule

// File: hw/umi_resp_convert.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module umi_resp_convert
    import tl2umi_pkg::*;
(
    input  logic        clk,
    input  logic        nreset,
    input  logic        resp_valid,
    input  umi_packet_t resp,
    output logic        resp_ready,
    output logic        d_valid,
    input  logic        d_ready,
    output tl_d_beat_t  d,
    output logic        put_acked
);

    logic       resp_fire;
    logic       supported;
    logic [2:0] ofs;
    tl_d_beat_t next_d;

    // Single D holding register, stall UMI while it is blocked
    assign resp_ready = !d_valid || d_ready;
    assign resp_fire  = resp_valid && resp_ready;

    assign ofs = resp.dstaddr[`TL2UMI_SRC_OFS_LSB +: 3];

    always_comb begin
        next_d        = '0;
        next_d.size   = resp.dstaddr[`TL2UMI_SRC_SIZE_LSB +: 3];
        next_d.source = resp.dstaddr[`TL2UMI_SRC_ID_LSB +: 5];
        supported     = 1'b1;
        case (resp.cmd.opcode)
            UMI_RESP_READ: begin
                next_d.opcode = TL_D_ACCESS_ACK_DATA;
                // Back into the original byte lanes
                next_d.data   = resp.data << {ofs, 3'b000};
            end
            UMI_RESP_WRITE: begin
                next_d.opcode = TL_D_ACCESS_ACK;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            d_valid <= 1'b0;
        end else if (resp_fire && supported) begin
            d_valid <= 1'b1;
        end else if (d_ready) begin
            d_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_fire && supported) begin
            d <= next_d;
        end
    end

    assign put_acked = d_valid && d_ready && (d.opcode == TL_D_ACCESS_ACK);

    d_stable_a: assert property (@(posedge clk) disable iff (!nreset)
        d_valid && !d_ready |=> d_valid && $stable(d));

endmodule

// File: hw/umi_req_issue.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module umi_req_issue
    import tl2umi_pkg::*;
(
    input  logic                   clk,
    input  logic                   nreset,
    input  logic [`TL2UMI_IDW-1:0] chipid,
    input  logic                   a_valid,
    input  a_decoded_t             decoded,
    output logic                   a_ready,
    input  logic                   put_acked,
    output logic                   req_valid,
    input  logic                   req_ready,
    output umi_packet_t            req
);

    issue_state_e state;
    logic         a_fire;
    umi_packet_t  next_req;

    // Output register free or draining, and no Put outstanding
    assign a_ready = (!req_valid || req_ready) && (state == ST_IDLE);
    assign a_fire  = a_valid && a_ready;

    always_comb begin
        next_req = '0;
        next_req.cmd.len = decoded.len;
        next_req.cmd.eom = 1'b1;
        if (decoded.kind == KIND_WRITE) begin
            next_req.cmd.opcode = UMI_REQ_WRITE;
            next_req.data       = decoded.data;
        end else begin
            next_req.cmd.opcode = UMI_REQ_READ;
        end
        next_req.dstaddr = decoded.dstaddr;

        // Tag fields come back in the response dstaddr
        next_req.srcaddr[`TL2UMI_CHIPID_LSB +: `TL2UMI_IDW] = chipid;
        next_req.srcaddr[`TL2UMI_SRC_OFS_LSB +: 3]  = decoded.offset;
        next_req.srcaddr[`TL2UMI_SRC_SIZE_LSB +: 3] = decoded.size;
        next_req.srcaddr[`TL2UMI_SRC_ID_LSB +: 5]   = decoded.source;
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state     <= ST_IDLE;
            req_valid <= 1'b0;
        end else begin
            // Unsupported opcodes are taken and dropped here
            if (a_fire && decoded.kind != KIND_NONE) begin
                req_valid <= 1'b1;
            end else if (req_ready) begin
                req_valid <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (a_fire && decoded.kind == KIND_WRITE) begin
                        state <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    if (put_acked) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (a_fire && decoded.kind != KIND_NONE) begin
            req <= next_req;
        end
    end

    req_stable_a: assert property (@(posedge clk) disable iff (!nreset)
        req_valid && !req_ready |=> req_valid && $stable(req));

    // Only a Put can produce an AccessAck
    ack_in_wait_a: assert property (@(posedge clk) disable iff (!nreset)
        put_acked |-> state == ST_WAIT_ACK);

endmodule

// File: hw/tl_a_decode.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module tl_a_decode
    import tl2umi_pkg::*;
(
    input  logic       clk,
    input  logic       nreset,
    input  logic       valid,
    input  tl_a_beat_t beat,
    output a_decoded_t decoded
);

    logic [2:0] first_one;
    logic [3:0] ones;

    // Lowest set mask bit, scanned from the top down
    always_comb begin
        first_one = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (beat.mask[i]) begin
                first_one = 3'(i);
            end
        end
    end

    always_comb begin
        ones = 4'd0;
        for (int i = 0; i < 8; i++) begin
            ones = ones + 4'(beat.mask[i]);
        end
    end

    always_comb begin
        decoded = '0;
        case (beat.opcode)
            TL_A_GET: decoded.kind = KIND_READ;
            TL_A_PUT_FULL, TL_A_PUT_PARTIAL: decoded.kind = KIND_WRITE;
            default: decoded.kind = KIND_NONE;
        endcase

        // Read length follows the TL size, write length the mask
        if (decoded.kind == KIND_READ) begin
            decoded.len = (8'd1 << beat.size) - 8'd1;
        end else begin
            decoded.len = 8'(ones) - 8'd1;
        end

        decoded.offset  = first_one;
        decoded.dstaddr = umi_addr_t'({beat.address[`TL2UMI_TLAW-1:3], first_one});
        decoded.data    = beat.data >> {first_one, 3'b000};
        decoded.size    = beat.size;
        decoded.source  = beat.source;
    end

    // Zero masks have no mask-less form
    mask_nonzero_a: assert property (@(posedge clk) disable iff (!nreset)
        valid |-> beat.mask != 8'h00);

endmodule

// File: hw/tl2umi_pkg.sv
`include "tl2umi_settings.svh"

package tl2umi_pkg;

    typedef logic [`TL2UMI_AW-1:0] umi_addr_t;
    typedef logic [`TL2UMI_DW-1:0] umi_data_t;

    typedef enum logic [2:0] {
        TL_A_PUT_FULL    = 3'd0,
        TL_A_PUT_PARTIAL = 3'd1,
        TL_A_GET         = 3'd4
    } tl_a_op_e;

    typedef enum logic [2:0] {
        TL_D_ACCESS_ACK      = 3'd0,
        TL_D_ACCESS_ACK_DATA = 3'd1
    } tl_d_op_e;

    typedef enum logic [4:0] {
        UMI_REQ_READ   = 5'd1,
        UMI_RESP_READ  = 5'd2,
        UMI_REQ_WRITE  = 5'd3,
        UMI_RESP_WRITE = 5'd4
    } umi_op_e;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_READ,
        KIND_WRITE
    } req_kind_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ACK
    } issue_state_e;

    // Only opcode, size, len and eom are used here
    typedef struct packed {
        logic [`TL2UMI_CW-24:0] rsvd_hi;
        logic                   eom;
        logic [5:0]             rsvd_mid;
        logic [7:0]             len;
        logic [2:0]             size;
        umi_op_e                opcode;
    } umi_cmd_t;

    typedef struct packed {
        umi_cmd_t  cmd;
        umi_addr_t dstaddr;
        umi_addr_t srcaddr;
        umi_data_t data;
    } umi_packet_t;

    typedef struct packed {
        tl_a_op_e                 opcode;
        logic [2:0]               param;
        logic [2:0]               size;
        logic [4:0]               source;
        logic [`TL2UMI_TLAW-1:0]  address;
        logic [7:0]               mask;
        logic [63:0]              data;
    } tl_a_beat_t;

    typedef struct packed {
        tl_d_op_e    opcode;
        logic [2:0]  size;
        logic [4:0]  source;
        logic [63:0] data;
    } tl_d_beat_t;

    typedef struct packed {
        req_kind_e  kind;
        logic [2:0] offset;
        logic [7:0] len;
        umi_addr_t  dstaddr;
        umi_data_t  data;
        logic [2:0] size;
        logic [4:0] source;
    } a_decoded_t;

endpackage

// File: hw/tl2umi_settings.svh
`ifndef TL2UMI_SETTINGS_SVH
`define TL2UMI_SETTINGS_SVH

// UMI packet field widths
`define TL2UMI_CW 32
`define TL2UMI_AW 64
`define TL2UMI_DW 64

// TileLink address width
`define TL2UMI_TLAW 56

// Chip id width
`define TL2UMI_IDW 16

// Source address user fields, echoed back in the response dstaddr
`define TL2UMI_SRC_OFS_LSB  32
`define TL2UMI_SRC_SIZE_LSB 24
`define TL2UMI_SRC_ID_LSB   16
`define TL2UMI_CHIPID_LSB   40

`endif
